/* hw/axil_slave_port.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

module axil_slave_port
  import blinky_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [`BLINKY_ADDR_W-1:0]     awaddr,
  input  logic                          awvalid,
  output logic                          awready,

  input  logic [`BLINKY_DATA_W-1:0]     wdata,
  input  logic [`BLINKY_DATA_W/8-1:0]   wstrb,
  input  logic                          wvalid,
  output logic                          wready,

  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,

  input  logic [`BLINKY_ADDR_W-1:0]     araddr,
  input  logic                          arvalid,
  output logic                          arready,

  output logic [`BLINKY_DATA_W-1:0]     rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,

  reg_bus_if.port                       bus
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACCEPT = 2'd1;
  localparam logic [1:0] ST_RESP   = 2'd2;

  logic [1:0]                w_state_q;
  logic [1:0]                r_state_q;
  axil_resp_e                bresp_q;
  axil_resp_e                rresp_q;
  logic [`BLINKY_DATA_W-1:0] rdata_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Address and data must both be present before we take either
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_state_q <= ST_IDLE;
    end else begin
      case (w_state_q)
        ST_IDLE: begin
          if (awvalid && wvalid) begin
            w_state_q <= ST_ACCEPT;
          end
        end
        ST_ACCEPT: begin
          w_state_q <= ST_RESP;
        end
        ST_RESP: begin
          if (bready) begin
            w_state_q <= ST_IDLE;
          end
        end
        default: begin
          w_state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Response latched while the register file answers
  always_ff @(posedge clk) begin
    if (w_state_q == ST_ACCEPT) begin
      bresp_q <= bus.wr_resp;
    end
  end

  assign awready     = (w_state_q == ST_ACCEPT);
  assign wready      = (w_state_q == ST_ACCEPT);
  assign bvalid      = (w_state_q == ST_RESP);
  assign bresp       = bresp_q;

  assign bus.wr_en   = (w_state_q == ST_ACCEPT);
  assign bus.wr_addr = awaddr;
  assign bus.wr_data = wdata;
  assign bus.wr_strb = wstrb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_state_q <= ST_IDLE;
    end else begin
      case (r_state_q)
        ST_IDLE: begin
          if (arvalid) begin
            r_state_q <= ST_ACCEPT;
          end
        end
        ST_ACCEPT: begin
          r_state_q <= ST_RESP;
        end
        ST_RESP: begin
          if (rready) begin
            r_state_q <= ST_IDLE;
          end
        end
        default: begin
          r_state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (r_state_q == ST_ACCEPT) begin
      rdata_q <= bus.rd_data;
      rresp_q <= bus.rd_resp;
    end
  end

  assign arready     = (r_state_q == ST_ACCEPT);
  assign rvalid      = (r_state_q == ST_RESP);
  assign rdata       = rdata_q;
  assign rresp       = rresp_q;

  assign bus.rd_en   = (r_state_q == ST_ACCEPT);
  assign bus.rd_addr = araddr;

  // Responses wait for the master with a frozen payload
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  a_aw_needs_w: assert property (@(posedge clk) disable iff (!rst_n)
    awready |-> wvalid);

endmodule

/* hw/blink_regs.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

module blink_regs
  import blinky_pkg::*;
#(
  parameter int CLK_FREQ = `BLINKY_CLK_FREQ
) (
  input  logic                      clk,
  input  logic                      rst_n,
  reg_bus_if.regs                   bus,
  output logic                      enable,
  output logic [`BLINKY_DATA_W-1:0] on_cycles,
  output logic [`BLINKY_DATA_W-1:0] period_cycles
);

  localparam int ADDR_W = `BLINKY_ADDR_W;
  localparam int DATA_W = `BLINKY_DATA_W;
  localparam int STRB_W = DATA_W / 8;
  localparam int IDX_W  = $clog2(`BLINKY_NUM_REGS);

  localparam logic [ADDR_W-1:0] NUM_REGS = ADDR_W'(`BLINKY_NUM_REGS);

  logic [DATA_W-1:0] regs_q [`BLINKY_NUM_REGS];
  logic [DATA_W-1:0] wr_word;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  logic              wr_hit;
  logic              rd_hit;

  // Value each register takes out of reset
  function automatic logic [DATA_W-1:0] reg_default(input logic [ADDR_W-1:0] addr);
    case (addr)
      REG_ON:     return DATA_W'(CLK_FREQ / 2);
      REG_PERIOD: return DATA_W'(CLK_FREQ);
      default:    return '0;
    endcase
  endfunction

  // Implemented bits per register
  function automatic logic [DATA_W-1:0] reg_mask(input logic [ADDR_W-1:0] addr);
    case (addr)
      REG_CTRL: return DATA_W'(1);
      default:  return '1;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_hit = (bus.wr_addr < NUM_REGS);
  assign rd_hit = (bus.rd_addr < NUM_REGS);
  assign wr_idx = bus.wr_addr[IDX_W-1:0];
  assign rd_idx = bus.rd_addr[IDX_W-1:0];

  // Byte lane merge over the current contents
  always_comb begin
    wr_word = wr_hit ? regs_q[wr_idx] : '0;
    for (int b = 0; b < STRB_W; b++) begin
      if (bus.wr_strb[b]) begin
        wr_word[8*b +: 8] = bus.wr_data[8*b +: 8];
      end
    end
    wr_word = wr_word & reg_mask(bus.wr_addr);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BLINKY_NUM_REGS; i++) begin
        regs_q[i] <= reg_default(ADDR_W'(i));
      end
    end else if (bus.wr_en && wr_hit) begin
      regs_q[wr_idx] <= wr_word;
    end
  end

  assign bus.wr_resp = wr_hit ? RESP_OKAY : RESP_DECERR;
  assign bus.rd_resp = rd_hit ? RESP_OKAY : RESP_DECERR;
  // Unmapped reads come back as zero
  assign bus.rd_data = rd_hit ? regs_q[rd_idx] : '0;

  // Timer settings
  assign enable        = regs_q[0][0];
  assign on_cycles     = regs_q[1];
  assign period_cycles = regs_q[2];

  a_en_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({bus.wr_en, bus.rd_en}));

endmodule

/* hw/blink_timer.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

module blink_timer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable,
  input  logic [`BLINKY_DATA_W-1:0] on_cycles,
  input  logic [`BLINKY_DATA_W-1:0] period_cycles,
  output logic                      led
);

  localparam int DATA_W = `BLINKY_DATA_W;

  logic [DATA_W-1:0] count_q;
  // One extra bit so the increment never wraps
  logic [DATA_W:0]   count_inc;
  logic              wrap;

  assign count_inc = {1'b0, count_q} + 1'b1;
  // Also true for period 0 or 1 so the count parks at 0
  assign wrap      = (count_inc >= {1'b0, period_cycles});

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Period counter and LED compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (!enable || wrap) begin
      count_q <= '0;
    end else begin
      count_q <= count_inc[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 1'b0;
    end else begin
      led <= enable && (count_q < on_cycles);
    end
  end

  // Count stays inside the period once the period has settled
  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    enable && $stable(period_cycles) |-> count_q < period_cycles || period_cycles < 2);

endmodule

/* hw/blinky_macros.svh */
`ifndef BLINKY_MACROS_SVH
`define BLINKY_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Blinker build constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Clock frequency in Hz, sets the default blink timing
`define BLINKY_CLK_FREQ 100_000_000

// AXI4-Lite bus widths
`define BLINKY_ADDR_W 8
`define BLINKY_DATA_W 32

// Mapped registers, word addressed from 0
`define BLINKY_NUM_REGS 3

`endif

/* hw/blinky_pkg.sv */
`include "blinky_macros.svh"

package blinky_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus response codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [`BLINKY_ADDR_W-1:0] {
    REG_CTRL   = 8'h00,
    REG_ON     = 8'h01,
    REG_PERIOD = 8'h02
  } reg_idx_e;

endpackage

/* hw/blinky_reg.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

module blinky_reg #(
  parameter int CLK_FREQ = `BLINKY_CLK_FREQ
) (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic                        led,

  input  logic [`BLINKY_ADDR_W-1:0]   s_axil_awaddr,
  input  logic                        s_axil_awvalid,
  output logic                        s_axil_awready,
  input  logic [`BLINKY_DATA_W-1:0]   s_axil_wdata,
  input  logic [`BLINKY_DATA_W/8-1:0] s_axil_wstrb,
  input  logic                        s_axil_wvalid,
  output logic                        s_axil_wready,
  output logic [1:0]                  s_axil_bresp,
  output logic                        s_axil_bvalid,
  input  logic                        s_axil_bready,

  input  logic [`BLINKY_ADDR_W-1:0]   s_axil_araddr,
  input  logic                        s_axil_arvalid,
  output logic                        s_axil_arready,
  output logic [`BLINKY_DATA_W-1:0]   s_axil_rdata,
  output logic [1:0]                  s_axil_rresp,
  output logic                        s_axil_rvalid,
  input  logic                        s_axil_rready
);

  logic                      enable;
  logic [`BLINKY_DATA_W-1:0] on_cycles;
  logic [`BLINKY_DATA_W-1:0] period_cycles;

  reg_bus_if bus_if ();

  axil_slave_port axil_slave_port_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .awaddr (s_axil_awaddr),
    .awvalid(s_axil_awvalid),
    .awready(s_axil_awready),
    .wdata  (s_axil_wdata),
    .wstrb  (s_axil_wstrb),
    .wvalid (s_axil_wvalid),
    .wready (s_axil_wready),
    .bresp  (s_axil_bresp),
    .bvalid (s_axil_bvalid),
    .bready (s_axil_bready),
    .araddr (s_axil_araddr),
    .arvalid(s_axil_arvalid),
    .arready(s_axil_arready),
    .rdata  (s_axil_rdata),
    .rresp  (s_axil_rresp),
    .rvalid (s_axil_rvalid),
    .rready (s_axil_rready),
    .bus    (bus_if.port)
  );

  blink_regs #(
    .CLK_FREQ(CLK_FREQ)
  ) blink_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (bus_if.regs),
    .enable       (enable),
    .on_cycles    (on_cycles),
    .period_cycles(period_cycles)
  );

  blink_timer blink_timer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .on_cycles    (on_cycles),
    .period_cycles(period_cycles),
    .led          (led)
  );

endmodule

/* hw/reg_bus_if.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

interface reg_bus_if import blinky_pkg::*; ();

  // Write access, one cycle per transfer
  logic                          wr_en;
  logic [`BLINKY_ADDR_W-1:0]     wr_addr;
  logic [`BLINKY_DATA_W-1:0]     wr_data;
  logic [`BLINKY_DATA_W/8-1:0]   wr_strb;
  axil_resp_e                    wr_resp;

  // Read access, answered in the same cycle
  logic                          rd_en;
  logic [`BLINKY_ADDR_W-1:0]     rd_addr;
  logic [`BLINKY_DATA_W-1:0]     rd_data;
  axil_resp_e                    rd_resp;

  modport port (
    output wr_en,
    output wr_addr,
    output wr_data,
    output wr_strb,
    input  wr_resp,
    output rd_en,
    output rd_addr,
    input  rd_data,
    input  rd_resp
  );

  modport regs (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  wr_strb,
    output wr_resp,
    input  rd_en,
    input  rd_addr,
    output rd_data,
    output rd_resp
  );

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the blinky_reg testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module blinky_reg_tb -f vlog.f -o blinky_reg_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/blinky_reg_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0

/* tb/blinky_reg_tb.sv */
`timescale 1ns/1ps
`include "blinky_macros.svh"

module blinky_reg_tb;

  localparam int         WAIT_LIMIT = 64;
  localparam logic [7:0] REG_LIMIT  = 8'(`BLINKY_NUM_REGS);
  localparam logic [1:0] OKAY       = 2'b00;
  localparam logic [1:0] DECERR     = 2'b11;

  logic                        clk;
  logic                        rst_n;
  logic                        led;
  logic [`BLINKY_ADDR_W-1:0]   s_axil_awaddr;
  logic                        s_axil_awvalid;
  logic                        s_axil_awready;
  logic [`BLINKY_DATA_W-1:0]   s_axil_wdata;
  logic [`BLINKY_DATA_W/8-1:0] s_axil_wstrb;
  logic                        s_axil_wvalid;
  logic                        s_axil_wready;
  logic [1:0]                  s_axil_bresp;
  logic                        s_axil_bvalid;
  logic                        s_axil_bready;
  logic [`BLINKY_ADDR_W-1:0]   s_axil_araddr;
  logic                        s_axil_arvalid;
  logic                        s_axil_arready;
  logic [`BLINKY_DATA_W-1:0]   s_axil_rdata;
  logic [1:0]                  s_axil_rresp;
  logic                        s_axil_rvalid;
  logic                        s_axil_rready;

  logic [31:0] lfsr_q;
  int          value_errors;
  int          timeouts;

  // Reference model state
  logic [31:0] sh_regs [`BLINKY_NUM_REGS];
  logic [31:0] sh_count;
  logic        exp_led;
  logic [1:0]  exp_bresp;
  logic [1:0]  exp_rresp;
  logic [31:0] exp_rdata;

  blinky_reg dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_fail(input string msg);
    value_errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : model
    logic [31:0] word;
    if (!rst_n) begin
      sh_regs[0] <= '0;
      sh_regs[1] <= 32'(`BLINKY_CLK_FREQ / 2);
      sh_regs[2] <= 32'(`BLINKY_CLK_FREQ);
      sh_count   <= '0;
      exp_led    <= 1'b0;
    end else begin
      if (s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready) begin
        exp_bresp <= (s_axil_awaddr < REG_LIMIT) ? OKAY : DECERR;
        word = sh_regs[s_axil_awaddr[1:0]];
        for (int b = 0; b < 4; b++) begin
          if (s_axil_wstrb[b]) begin
            word[8*b +: 8] = s_axil_wdata[8*b +: 8];
          end
        end
        // Control only keeps its enable bit
        if (s_axil_awaddr == 8'h00) begin
          word = {31'b0, word[0]};
        end
        if (s_axil_awaddr < REG_LIMIT) begin
          sh_regs[s_axil_awaddr[1:0]] <= word;
        end
      end
      if (s_axil_arvalid && s_axil_arready) begin
        exp_rresp <= (s_axil_araddr < REG_LIMIT) ? OKAY : DECERR;
        exp_rdata <= (s_axil_araddr < REG_LIMIT) ? sh_regs[s_axil_araddr[1:0]] : '0;
      end
      // Wraps after the last count and parks at 0 for periods below 2
      if (!sh_regs[0][0] || sh_regs[2] < 32'd2 || sh_count >= sh_regs[2] - 32'd1) begin
        sh_count <= '0;
      end else begin
        sh_count <= sh_count + 32'd1;
      end
      exp_led <= sh_regs[0][0] && (sh_count < sh_regs[1]);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_reset_state: assert property (@(posedge clk)
    !rst_n |=> !led && !s_axil_bvalid && !s_axil_rvalid)
    else report_fail("led, bvalid or rvalid high after reset");
  a_led_model: assert property (@(posedge clk) disable iff (!rst_n) led == exp_led)
    else report_fail($sformatf("led %b, expected %b", led, exp_led));
  a_led_off: assert property (@(posedge clk) disable iff (!rst_n) !sh_regs[0][0] |=> !led)
    else report_fail("led high after enable cleared");
  a_w_ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_wready == s_axil_awready)
    else report_fail("wready and awready out of step");
  a_bresp_model: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid |-> s_axil_bresp == exp_bresp)
    else report_fail($sformatf("bresp %b, expected %b", s_axil_bresp, exp_bresp));
  a_rdata_model: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_rvalid |-> s_axil_rdata == exp_rdata && s_axil_rresp == exp_rresp)
    else report_fail($sformatf("rdata %h rresp %b, expected %h %b",
                               s_axil_rdata, s_axil_rresp, exp_rdata, exp_rresp));
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
    else report_fail("write response dropped or changed before bready");
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable({s_axil_rdata, s_axil_rresp}))
    else report_fail("read response dropped or changed before rready");
  a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid |-> !s_axil_awready)
    else report_fail("second write accepted while bvalid pending");
  a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_rvalid |-> !s_axil_arready)
    else report_fail("second read accepted while rvalid pending");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic hs_level(input int sel);
    case (sel)
      0:       return s_axil_awready;
      1:       return s_axil_bvalid;
      2:       return s_axil_arready;
      default: return s_axil_rvalid;
    endcase
  endfunction

  task automatic wait_high(input int sel, input string what, output bit ok);
    int n;
    n = 0;
    @(posedge clk);
    while (!hs_level(sel) && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = hs_level(sel);
    if (!ok) begin
      timeouts++;
      $display("Timed out at %0t ns waiting for %s", $time, what);
    end
  endtask

  // With chain set the same request stays queued behind the response
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, input bit chain);
    bit ok;
    @(posedge clk);
    s_axil_awaddr  <= addr;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= strb;
    s_axil_awvalid <= 1'b1;
    s_axil_wvalid  <= 1'b1;
    wait_high(0, "awready", ok);
    s_axil_awvalid <= chain && ok;
    s_axil_wvalid  <= chain && ok;
    if (ok) begin
      wait_high(1, "bvalid", ok);
    end
    if (ok) begin
      repeat (hold) @(posedge clk);
      s_axil_bready <= 1'b1;
      @(posedge clk);
      s_axil_bready <= 1'b0;
    end
  endtask

  task automatic axi_read(input logic [7:0] addr, input int hold, input bit chain);
    bit ok;
    @(posedge clk);
    s_axil_araddr  <= addr;
    s_axil_arvalid <= 1'b1;
    wait_high(2, "arready", ok);
    s_axil_arvalid <= chain && ok;
    if (ok) begin
      wait_high(3, "rvalid", ok);
    end
    if (ok) begin
      repeat (hold) @(posedge clk);
      s_axil_rready <= 1'b1;
      @(posedge clk);
      s_axil_rready <= 1'b0;
    end
  endtask

  initial begin
    logic [7:0]  addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          hold;
    lfsr_q         = 32'h05411efb;
    value_errors   = 0;
    timeouts       = 0;
    rst_n          = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // Defaults
    for (int a = 0; a < `BLINKY_NUM_REGS; a++) begin
      axi_read(8'(a), 0, 1'b0);
    end

    // Strobed writes with readback
    for (int i = 0; i < 6; i++) begin
      addr = 8'(i % `BLINKY_NUM_REGS);
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      axi_write(addr, data, strb, 0, 1'b0);
      axi_read(addr, 0, 1'b0);
    end

    // Blink pattern of 3 on out of 5
    axi_write(8'h01, 32'd3, 4'hf, 0, 1'b0);
    axi_write(8'h02, 32'd5, 4'hf, 0, 1'b0);
    axi_write(8'h00, 32'd1, 4'hf, 0, 1'b0);
    repeat (20) @(posedge clk);
    axi_write(8'h00, 32'd0, 4'hf, 0, 1'b0);
    repeat (4) @(posedge clk);

    // Unmapped addresses
    addr = 8'(rand_bits(8));
    addr = (addr < REG_LIMIT) ? addr + REG_LIMIT : addr;
    axi_write(addr, rand_bits(32), 4'hf, 0, 1'b0);
    addr = 8'(rand_bits(8));
    addr = (addr < REG_LIMIT) ? addr + REG_LIMIT : addr;
    axi_read(addr, 0, 1'b0);
    for (int a = 0; a < `BLINKY_NUM_REGS; a++) begin
      axi_read(8'(a), 0, 1'b0);
    end

    // Back-pressure with a second request waiting
    for (int i = 0; i < 4; i++) begin
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      hold = int'(rand_bits(3)) + 1;
      axi_write(8'h01, data, strb, hold, 1'b1);
      axi_write(8'h01, data, strb, 0, 1'b0);
      hold = int'(rand_bits(3)) + 1;
      axi_read(8'h02, hold, 1'b1);
      axi_read(8'h02, 0, 1'b0);
    end

    repeat (2) @(posedge clk);
    $display("Summary: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors + timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/blinky_pkg.sv
hw/reg_bus_if.sv
hw/axil_slave_port.sv
hw/blink_regs.sv
hw/blink_timer.sv
hw/blinky_reg.sv
tb/blinky_reg_tb.sv
